// File: ntt_pkg.sv
// ML-DSA NTT shared definitions
// modulus, coefficient types and butterfly modes

`default_nettype none

package ntt_pkg;

    // ------------------------------------------------------------
    // coefficient arithmetic
    // ------------------------------------------------------------
    localparam int unsigned COEFF_W = 23;
    localparam int unsigned PROD_W  = 2 * COEFF_W;

    // ML-DSA prime 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] NTT_Q = 23'd8380417;

    // always holds a value below NTT_Q
    typedef logic [COEFF_W-1:0] coeff_t;
    // full product before reduction
    typedef logic [PROD_W-1:0]  prod_t;

    // ------------------------------------------------------------
    // operating modes
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

endpackage

`default_nettype wire

// File: ntt_bf_if.sv
// operand and result bundle between the router and one butterfly

`timescale 1ns/1ps
`default_nettype none

interface ntt_bf_if;

    ntt_pkg::coeff_t u;
    ntt_pkg::coeff_t v;
    ntt_pkg::coeff_t w;
    ntt_pkg::coeff_t res_u;
    ntt_pkg::coeff_t res_v;
    ntt_pkg::coeff_t res_pw;

    // operand side
    modport router (
        output u, v, w,
        input  res_u, res_v, res_pw
    );

    // butterfly side
    modport bf (
        input  u, v, w,
        output res_u, res_v, res_pw
    );

endinterface

`default_nettype wire

// File: ntt_mod_mult.sv
// pipelined modular multiplier
// a_i * b_i mod NTT_Q with the result after MUL_STAGES cycles

`timescale 1ns/1ps
`default_nettype none

module ntt_mod_mult #(
    parameter int MUL_STAGES = 3
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::coeff_t a_i,
    input  ntt_pkg::coeff_t b_i,
    output ntt_pkg::coeff_t p_o
);

    ntt_pkg::prod_t                   prod;
    ntt_pkg::prod_t                   prod_red;
    ntt_pkg::coeff_t [MUL_STAGES-1:0] pipe_q;

    // full 46-bit product and its remainder
    always_comb begin
        prod     = ntt_pkg::prod_t'(a_i) * ntt_pkg::prod_t'(b_i);
        prod_red = prod % ntt_pkg::prod_t'(ntt_pkg::NTT_Q);
    end

    // result pipeline
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pipe_q <= '0;
        end else if (zeroize_i) begin
            pipe_q <= '0;
        end else begin
            pipe_q[0] <= prod_red[ntt_pkg::COEFF_W-1:0];
            for (int i = 1; i < MUL_STAGES; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign p_o = pipe_q[MUL_STAGES-1];

endmodule

`default_nettype wire

// File: ntt_butterfly.sv
// NTT butterfly for ct, gs and the pointwise modes
// every mode has a latency of MUL_STAGES + 1 cycles

`timescale 1ns/1ps
`default_nettype none

module ntt_butterfly #(
    parameter int MUL_STAGES = 3
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize_i,
    input  ntt_pkg::mode_t mode_i,
    ntt_bf_if.bf           bf
);

    ntt_pkg::coeff_t                  sum_q, diff_q, w_q;
    ntt_pkg::coeff_t [MUL_STAGES-1:0] line_q;
    ntt_pkg::coeff_t                  line_in, line_out;
    ntt_pkg::coeff_t                  mul_a, mul_b, mul_p;
    ntt_pkg::coeff_t                  fin_u_q, fin_v_q;

    function automatic ntt_pkg::coeff_t mod_add(
        input ntt_pkg::coeff_t a,
        input ntt_pkg::coeff_t b
    );
        logic [ntt_pkg::COEFF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, ntt_pkg::NTT_Q}) begin
            s = s - {1'b0, ntt_pkg::NTT_Q};
        end
        return s[ntt_pkg::COEFF_W-1:0];
    endfunction

    function automatic ntt_pkg::coeff_t mod_sub(
        input ntt_pkg::coeff_t a,
        input ntt_pkg::coeff_t b
    );
        logic [ntt_pkg::COEFF_W:0] d;
        if (a >= b) begin
            d = {1'b0, a} - {1'b0, b};
        end else begin
            d = {1'b0, a} + {1'b0, ntt_pkg::NTT_Q} - {1'b0, b};
        end
        return d[ntt_pkg::COEFF_W-1:0];
    endfunction

    // ------------------------------------------------------------
    // first stage registers sum, difference and twiddle for gs/pwa/pws
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q  <= '0;
            diff_q <= '0;
            w_q    <= '0;
        end else if (zeroize_i) begin
            sum_q  <= '0;
            diff_q <= '0;
            w_q    <= '0;
        end else begin
            sum_q  <= mod_add(bf.u, bf.v);
            diff_q <= mod_sub(bf.u, bf.v);
            w_q    <= bf.w;
        end
    end

    // multiplier operands and the delay line input per mode
    always_comb begin
        mul_a   = '0;
        mul_b   = '0;
        line_in = '0;
        case (mode_i)
            ntt_pkg::ct: begin
                mul_a   = bf.v;
                mul_b   = bf.w;
                line_in = bf.u;
            end
            ntt_pkg::gs: begin
                mul_a   = diff_q;
                mul_b   = w_q;
                line_in = sum_q;
            end
            ntt_pkg::pwm: begin
                mul_a = bf.u;
                mul_b = bf.v;
            end
            ntt_pkg::pwa: line_in = sum_q;
            default:      line_in = diff_q;
        endcase
    end

    ntt_mod_mult #(
        .MUL_STAGES(MUL_STAGES)
    ) u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (mul_p)
    );

    // ------------------------------------------------------------
    // delay line in parallel with the multiplier and the final add/sub
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            line_q  <= '0;
            fin_u_q <= '0;
            fin_v_q <= '0;
        end else if (zeroize_i) begin
            line_q  <= '0;
            fin_u_q <= '0;
            fin_v_q <= '0;
        end else begin
            line_q[0] <= line_in;
            for (int i = 1; i < MUL_STAGES; i++) begin
                line_q[i] <= line_q[i-1];
            end
            // in pwm the line carries zero, so fin_u_q is the product
            fin_u_q <= mod_add(line_out, mul_p);
            fin_v_q <= mod_sub(line_out, mul_p);
        end
    end

    assign line_out = line_q[MUL_STAGES-1];

    // ct ends in the final registers while gs leaves straight from line and multiplier
    assign bf.res_u  = (mode_i == ntt_pkg::ct)  ? fin_u_q : line_out;
    assign bf.res_v  = (mode_i == ntt_pkg::ct)  ? fin_v_q : mul_p;
    assign bf.res_pw = (mode_i == ntt_pkg::pwm) ? fin_u_q : line_out;

endmodule

`default_nettype wire

// File: ntt_operand_router.sv
// operand selection for the two butterfly stages
// holds the stage-2 twiddle delay lines

`timescale 1ns/1ps
`default_nettype none

module ntt_operand_router #(
    parameter int MUL_STAGES = 3
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::mode_t  mode_i,
    input  ntt_pkg::coeff_t u00_i,
    input  ntt_pkg::coeff_t v00_i,
    input  ntt_pkg::coeff_t w00_i,
    input  ntt_pkg::coeff_t u01_i,
    input  ntt_pkg::coeff_t v01_i,
    input  ntt_pkg::coeff_t w01_i,
    input  ntt_pkg::coeff_t w10_i,
    input  ntt_pkg::coeff_t w11_i,
    input  ntt_pkg::coeff_t pw_u0_i,
    input  ntt_pkg::coeff_t pw_u1_i,
    input  ntt_pkg::coeff_t pw_u2_i,
    input  ntt_pkg::coeff_t pw_u3_i,
    input  ntt_pkg::coeff_t pw_v0_i,
    input  ntt_pkg::coeff_t pw_v1_i,
    input  ntt_pkg::coeff_t pw_v2_i,
    input  ntt_pkg::coeff_t pw_v3_i,
    ntt_bf_if.router        s00,
    ntt_bf_if.router        s01,
    ntt_bf_if.router        s10,
    ntt_bf_if.router        s11
);

    // butterfly latency
    localparam int L = MUL_STAGES + 1;

    ntt_pkg::coeff_t [L-1:0] w10_q;
    ntt_pkg::coeff_t [L-1:0] w11_q;
    logic                    pw_mode;

    assign pw_mode = mode_i inside {ntt_pkg::pwm, ntt_pkg::pwa, ntt_pkg::pws};

    // stage-2 twiddles wait for the stage-1 results
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_q <= '0;
            w11_q <= '0;
        end else if (zeroize_i) begin
            w10_q <= '0;
            w11_q <= '0;
        end else begin
            w10_q[0] <= w10_i;
            w11_q[0] <= w11_i;
            for (int i = 1; i < L; i++) begin
                w10_q[i] <= w10_q[i-1];
                w11_q[i] <= w11_q[i-1];
            end
        end
    end

    // ------------------------------------------------------------
    // pointwise lanes run all four butterflies in parallel
    // ------------------------------------------------------------
    always_comb begin
        if (pw_mode) begin
            s00.u = pw_u0_i;
            s00.v = pw_v0_i;
            s01.u = pw_u1_i;
            s01.v = pw_v1_i;
            s10.u = pw_u2_i;
            s10.v = pw_v2_i;
            s11.u = pw_u3_i;
            s11.v = pw_v3_i;
            s00.w = '0;
            s01.w = '0;
            s10.w = '0;
            s11.w = '0;
        end else begin
            s00.u = u00_i;
            s00.v = v00_i;
            s00.w = w00_i;
            s01.u = u01_i;
            s01.v = v01_i;
            s01.w = w01_i;
            // crosswise feed of the stage-1 results
            s10.u = s00.res_u;
            s10.v = s01.res_u;
            s10.w = w10_q[L-1];
            s11.u = s00.res_v;
            s11.v = s01.res_v;
            s11.w = w11_q[L-1];
        end
    end

endmodule

`default_nettype wire

// File: ntt_ready_tracker.sv
// ready generation by delaying enable with the latency of the current mode

`timescale 1ns/1ps
`default_nettype none

module ntt_ready_tracker #(
    parameter int MUL_STAGES = 3
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize_i,
    input  ntt_pkg::mode_t mode_i,
    input  logic           enable_i,
    output logic           ready_o
);

    localparam int L = MUL_STAGES + 1;

    logic [2*L-1:0] en_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q <= '0;
        end else if (zeroize_i) begin
            en_q <= '0;
        end else begin
            en_q <= {en_q[2*L-2:0], enable_i};
        end
    end

    // two stages for ct/gs and one for pointwise
    assign ready_o = (mode_i inside {ntt_pkg::ct, ntt_pkg::gs}) ? en_q[2*L-1] : en_q[L-1];

endmodule

`default_nettype wire

// File: ntt_butterfly_2x2.sv
// 2x2 NTT butterfly unit for ML-DSA coefficients
// operand router, two stages of two butterflies and ready tracking

`timescale 1ns/1ps
`default_nettype none

module ntt_butterfly_2x2 #(
    parameter int MUL_STAGES = 3
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::mode_t  mode_i,
    input  logic            enable_i,
    input  ntt_pkg::coeff_t u00_i,
    input  ntt_pkg::coeff_t v00_i,
    input  ntt_pkg::coeff_t w00_i,
    input  ntt_pkg::coeff_t u01_i,
    input  ntt_pkg::coeff_t v01_i,
    input  ntt_pkg::coeff_t w01_i,
    input  ntt_pkg::coeff_t w10_i,
    input  ntt_pkg::coeff_t w11_i,
    input  ntt_pkg::coeff_t pw_u0_i,
    input  ntt_pkg::coeff_t pw_u1_i,
    input  ntt_pkg::coeff_t pw_u2_i,
    input  ntt_pkg::coeff_t pw_u3_i,
    input  ntt_pkg::coeff_t pw_v0_i,
    input  ntt_pkg::coeff_t pw_v1_i,
    input  ntt_pkg::coeff_t pw_v2_i,
    input  ntt_pkg::coeff_t pw_v3_i,
    output ntt_pkg::coeff_t u20_o,
    output ntt_pkg::coeff_t v20_o,
    output ntt_pkg::coeff_t u21_o,
    output ntt_pkg::coeff_t v21_o,
    output ntt_pkg::coeff_t pwo_uv0_o,
    output ntt_pkg::coeff_t pwo_uv1_o,
    output ntt_pkg::coeff_t pwo_uv2_o,
    output ntt_pkg::coeff_t pwo_uv3_o,
    output logic            ready_o
);

    ntt_bf_if if00 ();
    ntt_bf_if if01 ();
    ntt_bf_if if10 ();
    ntt_bf_if if11 ();

    // ------------------------------------------------------------
    // operand routing
    // ------------------------------------------------------------
    ntt_operand_router #(
        .MUL_STAGES(MUL_STAGES)
    ) u_router (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .u00_i     (u00_i),
        .v00_i     (v00_i),
        .w00_i     (w00_i),
        .u01_i     (u01_i),
        .v01_i     (v01_i),
        .w01_i     (w01_i),
        .w10_i     (w10_i),
        .w11_i     (w11_i),
        .pw_u0_i   (pw_u0_i),
        .pw_u1_i   (pw_u1_i),
        .pw_u2_i   (pw_u2_i),
        .pw_u3_i   (pw_u3_i),
        .pw_v0_i   (pw_v0_i),
        .pw_v1_i   (pw_v1_i),
        .pw_v2_i   (pw_v2_i),
        .pw_v3_i   (pw_v3_i),
        .s00       (if00.router),
        .s01       (if01.router),
        .s10       (if10.router),
        .s11       (if11.router)
    );

    // ------------------------------------------------------------
    // butterflies, stage 1 then stage 2
    // ------------------------------------------------------------
    ntt_butterfly #(.MUL_STAGES(MUL_STAGES)) u_bf00 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .mode_i(mode_i), .bf(if00.bf)
    );

    ntt_butterfly #(.MUL_STAGES(MUL_STAGES)) u_bf01 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .mode_i(mode_i), .bf(if01.bf)
    );

    ntt_butterfly #(.MUL_STAGES(MUL_STAGES)) u_bf10 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .mode_i(mode_i), .bf(if10.bf)
    );

    ntt_butterfly #(.MUL_STAGES(MUL_STAGES)) u_bf11 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .mode_i(mode_i), .bf(if11.bf)
    );

    ntt_ready_tracker #(.MUL_STAGES(MUL_STAGES)) u_ready (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .mode_i(mode_i), .enable_i(enable_i), .ready_o(ready_o)
    );

    // network outputs
    assign u20_o = if10.res_u;
    assign v20_o = if10.res_v;
    assign u21_o = if11.res_u;
    assign v21_o = if11.res_v;

    // pointwise lanes
    assign pwo_uv0_o = if00.res_pw;
    assign pwo_uv1_o = if01.res_pw;
    assign pwo_uv2_o = if10.res_pw;
    assign pwo_uv3_o = if11.res_pw;

endmodule

`default_nettype wire

// File: tb_ntt_model.svh
// reference model for the 2x2 NTT butterfly unit
// modular arithmetic, single butterflies and the two-stage network
`ifndef TB_NTT_MODEL_SVH
`define TB_NTT_MODEL_SVH

function automatic ntt_pkg::coeff_t add_mod(input ntt_pkg::coeff_t a, input ntt_pkg::coeff_t b);
    longint s;
    s = (longint'(a) + longint'(b)) % longint'(ntt_pkg::NTT_Q);
    return ntt_pkg::coeff_t'(s);
endfunction

function automatic ntt_pkg::coeff_t sub_mod(input ntt_pkg::coeff_t a, input ntt_pkg::coeff_t b);
    longint d;
    d = (longint'(a) + longint'(ntt_pkg::NTT_Q) - longint'(b)) % longint'(ntt_pkg::NTT_Q);
    return ntt_pkg::coeff_t'(d);
endfunction

// double and add over the bits of b, most significant first
function automatic ntt_pkg::coeff_t mul_mod(input ntt_pkg::coeff_t a, input ntt_pkg::coeff_t b);
    ntt_pkg::coeff_t acc;
    acc = '0;
    for (int i = ntt_pkg::COEFF_W - 1; i >= 0; i--) begin
        acc = add_mod(acc, acc);
        if (b[i]) begin
            acc = add_mod(acc, a);
        end
    end
    return acc;
endfunction

// one ct or gs butterfly
task automatic butterfly_result(input ntt_pkg::mode_t mode, input ntt_pkg::coeff_t u,
                                input ntt_pkg::coeff_t v, input ntt_pkg::coeff_t w,
                                output ntt_pkg::coeff_t ru, output ntt_pkg::coeff_t rv);
    if (mode == ntt_pkg::ct) begin
        ru = add_mod(u, mul_mod(v, w));
        rv = sub_mod(u, mul_mod(v, w));
    end else begin
        ru = add_mod(u, v);
        rv = mul_mod(sub_mod(u, v), w);
    end
endtask

// pointwise lane
function automatic ntt_pkg::coeff_t lane_result(input ntt_pkg::mode_t mode,
                                                input ntt_pkg::coeff_t u,
                                                input ntt_pkg::coeff_t v);
    case (mode)
        ntt_pkg::pwm: return mul_mod(u, v);
        ntt_pkg::pwa: return add_mod(u, v);
        default:      return sub_mod(u, v);
    endcase
endfunction

`endif

// File: tb_ntt_butterfly_2x2.sv
// testbench for the 2x2 NTT butterfly unit
// random and edge operands in all five modes checked against a reference model

`timescale 1ns/1ps
`default_nettype none

module tb_ntt_butterfly_2x2;

    localparam int MUL_STAGES = 3;
    localparam int L          = MUL_STAGES + 1;
    localparam int DRAIN_MAX  = 4 * L + 10;
    // operand kinds for the stimulus
    localparam int OP_RANDOM  = 0;
    localparam int OP_EDGE    = 1;
    localparam int OP_ZERO    = 2;

    `include "tb_ntt_model.svh"

    typedef struct packed {
        ntt_pkg::mode_t               mode;
        logic [31:0]                  due;
        ntt_pkg::coeff_t [7:0]        res;
    } exp_t;

    logic            clk;
    logic            reset_n;
    logic            zeroize_i;
    logic            enable_i;
    ntt_pkg::mode_t  mode_i;
    ntt_pkg::coeff_t u00_i, v00_i, w00_i, u01_i, v01_i, w01_i, w10_i, w11_i;
    ntt_pkg::coeff_t pw_u0_i, pw_u1_i, pw_u2_i, pw_u3_i;
    ntt_pkg::coeff_t pw_v0_i, pw_v1_i, pw_v2_i, pw_v3_i;
    ntt_pkg::coeff_t u20_o, v20_o, u21_o, v21_o;
    ntt_pkg::coeff_t pwo_uv0_o, pwo_uv1_o, pwo_uv2_o, pwo_uv3_o;
    logic            ready_o;

    integer          seed = 63167;
    logic [31:0]     cycle;
    exp_t            exp_q[$];

    ntt_butterfly_2x2 #(.MUL_STAGES(MUL_STAGES)) u_ntt_butterfly_2x2 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .enable_i(enable_i),
        .u00_i(u00_i), .v00_i(v00_i), .w00_i(w00_i),
        .u01_i(u01_i), .v01_i(v01_i), .w01_i(w01_i),
        .w10_i(w10_i), .w11_i(w11_i),
        .pw_u0_i(pw_u0_i), .pw_u1_i(pw_u1_i), .pw_u2_i(pw_u2_i), .pw_u3_i(pw_u3_i),
        .pw_v0_i(pw_v0_i), .pw_v1_i(pw_v1_i), .pw_v2_i(pw_v2_i), .pw_v3_i(pw_v3_i),
        .u20_o(u20_o), .v20_o(v20_o), .u21_o(u21_o), .v21_o(v21_o),
        .pwo_uv0_o(pwo_uv0_o), .pwo_uv1_o(pwo_uv1_o),
        .pwo_uv2_o(pwo_uv2_o), .pwo_uv3_o(pwo_uv3_o),
        .ready_o(ready_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "simulation stopped");
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    function automatic ntt_pkg::coeff_t pick_coeff(input int kind);
        logic [31:0] r;
        r = $random(seed);
        if (kind == OP_ZERO) begin
            return '0;
        end else if (kind == OP_EDGE) begin
            case (r % 3)
                0:       return '0;
                1:       return 23'd1;
                default: return ntt_pkg::NTT_Q - 23'd1;
            endcase
        end
        return ntt_pkg::coeff_t'(r % ntt_pkg::NTT_Q);
    endfunction

    task automatic drive_inputs(input logic en, input logic zero, input int kind);
        @(posedge clk);
        enable_i  <= en;
        zeroize_i <= zero;
        u00_i     <= pick_coeff(kind);
        v00_i     <= pick_coeff(kind);
        w00_i     <= pick_coeff(kind);
        u01_i     <= pick_coeff(kind);
        v01_i     <= pick_coeff(kind);
        w01_i     <= pick_coeff(kind);
        w10_i     <= pick_coeff(kind);
        w11_i     <= pick_coeff(kind);
        pw_u0_i   <= pick_coeff(kind);
        pw_u1_i   <= pick_coeff(kind);
        pw_u2_i   <= pick_coeff(kind);
        pw_u3_i   <= pick_coeff(kind);
        pw_v0_i   <= pick_coeff(kind);
        pw_v1_i   <= pick_coeff(kind);
        pw_v2_i   <= pick_coeff(kind);
        pw_v3_i   <= pick_coeff(kind);
    endtask

    // gaps of zero give back-to-back operations
    task automatic run_ops(input int count, input int kind);
        logic [31:0] gap;
        for (int i = 0; i < count; i++) begin
            drive_inputs(1'b1, 1'b0, kind);
            gap = $random(seed) & 3;
            repeat (gap) drive_inputs(1'b0, 1'b0, kind);
        end
    endtask

    // idle cycles with zero operands where nothing may come out
    task automatic expect_idle(input int count);
        repeat (count) begin
            drive_inputs(1'b0, 1'b0, OP_ZERO);
            @(negedge clk);
            check_value("ready_o", 0, ready_o);
            check_value("u20_o", 0, u20_o);
            check_value("v20_o", 0, v20_o);
            check_value("u21_o", 0, u21_o);
            check_value("v21_o", 0, v21_o);
            check_value("pwo_uv0_o", 0, pwo_uv0_o);
            check_value("pwo_uv1_o", 0, pwo_uv1_o);
            check_value("pwo_uv2_o", 0, pwo_uv2_o);
            check_value("pwo_uv3_o", 0, pwo_uv3_o);
        end
    endtask

    // old enables must leave the shift register before the mode changes
    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == DRAIN_MAX) begin
                $display("timeout: results of the %s operations never arrived", what);
                $display("test failed");
                $fatal(1, "simulation stopped");
            end
            drive_inputs(1'b0, 1'b0, OP_ZERO);
            waited++;
        end
        repeat (2 * L + 1) drive_inputs(1'b0, 1'b0, OP_ZERO);
    endtask

    task automatic set_mode(input ntt_pkg::mode_t m);
        @(posedge clk);
        mode_i <= m;
    endtask

    // ------------------------------------------------------------
    // expected results and response checking
    // ------------------------------------------------------------
    task automatic predict_outputs(output exp_t e);
        ntt_pkg::coeff_t a0, b0, a1, b1, r0, r1, r2, r3;
        e      = '0;
        e.mode = mode_i;
        if (mode_i == ntt_pkg::ct || mode_i == ntt_pkg::gs) begin
            e.due = cycle + 2 * L;
            butterfly_result(mode_i, u00_i, v00_i, w00_i, a0, b0);
            butterfly_result(mode_i, u01_i, v01_i, w01_i, a1, b1);
            // stage 2 takes the stage-1 results crosswise
            butterfly_result(mode_i, a0, a1, w10_i, r0, r1);
            butterfly_result(mode_i, b0, b1, w11_i, r2, r3);
            e.res[0] = r0;
            e.res[1] = r1;
            e.res[2] = r2;
            e.res[3] = r3;
        end else begin
            e.due    = cycle + L;
            e.res[4] = lane_result(mode_i, pw_u0_i, pw_v0_i);
            e.res[5] = lane_result(mode_i, pw_u1_i, pw_v1_i);
            e.res[6] = lane_result(mode_i, pw_u2_i, pw_v2_i);
            e.res[7] = lane_result(mode_i, pw_u3_i, pw_v3_i);
        end
    endtask

    always @(negedge clk) begin : monitor
        exp_t e;
        if (reset_n) begin
            if (ready_o) begin
                check_value("ready_o in flight", 1, exp_q.size() != 0);
                e = exp_q.pop_front();
                check_value("ready_o cycle", e.due, cycle);
                if (e.mode == ntt_pkg::ct || e.mode == ntt_pkg::gs) begin
                    check_value("u20_o", e.res[0], u20_o);
                    check_value("v20_o", e.res[1], v20_o);
                    check_value("u21_o", e.res[2], u21_o);
                    check_value("v21_o", e.res[3], v21_o);
                end else begin
                    check_value("pwo_uv0_o", e.res[4], pwo_uv0_o);
                    check_value("pwo_uv1_o", e.res[5], pwo_uv1_o);
                    check_value("pwo_uv2_o", e.res[6], pwo_uv2_o);
                    check_value("pwo_uv3_o", e.res[7], pwo_uv3_o);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                check_value("ready_o", 1, 0);
            end
            // the zeroize edge drops everything in flight
            if (zeroize_i) begin
                exp_q.delete();
            end else if (enable_i) begin
                predict_outputs(e);
                exp_q.push_back(e);
            end
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        enable_i  = 1'b0;
        mode_i    = ntt_pkg::ct;
        {u00_i, v00_i, w00_i, u01_i, v01_i, w01_i, w10_i, w11_i} = '0;
        {pw_u0_i, pw_u1_i, pw_u2_i, pw_u3_i} = '0;
        {pw_v0_i, pw_v1_i, pw_v2_i, pw_v3_i} = '0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        expect_idle(2 * L + 2);

        run_ops(200, OP_RANDOM);
        wait_drained("ct");
        set_mode(ntt_pkg::gs);
        run_ops(200, OP_RANDOM);
        wait_drained("gs");
        set_mode(ntt_pkg::pwm);
        run_ops(100, OP_RANDOM);
        wait_drained("pwm");
        set_mode(ntt_pkg::pwa);
        run_ops(100, OP_RANDOM);
        wait_drained("pwa");
        set_mode(ntt_pkg::pws);
        run_ops(100, OP_RANDOM);
        wait_drained("pws");

        // zeroize with operations in flight in both kinds of mode
        set_mode(ntt_pkg::ct);
        repeat (6) drive_inputs(1'b1, 1'b0, OP_RANDOM);
        drive_inputs(1'b0, 1'b1, OP_ZERO);
        expect_idle(2 * L + 2);
        set_mode(ntt_pkg::pwm);
        repeat (3) drive_inputs(1'b1, 1'b0, OP_RANDOM);
        drive_inputs(1'b0, 1'b1, OP_ZERO);
        expect_idle(2 * L + 2);

        // operands 0, 1 and Q-1 exercise the modular wrap
        for (int m = 0; m < 5; m++) begin
            set_mode(ntt_pkg::mode_t'(m));
            run_ops(40, OP_EDGE);
            wait_drained("edge operand");
        end

        if (exp_q.size() != 0) begin
            $display("expected results are left over at the end of the run");
            $display("test failed");
            $fatal(1, "simulation stopped");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
ntt_pkg.sv
ntt_bf_if.sv
ntt_mod_mult.sv
ntt_butterfly.sv
ntt_operand_router.sv
ntt_ready_tracker.sv
ntt_butterfly_2x2.sv
tb_ntt_butterfly_2x2.sv
